// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

check:
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
src/dcache_pkg.sv
src/dcache_line_ram.sv
src/dcache_refill_buffer.sv
src/dcache_write_channel.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/mem_model.sv
test/tb_dcache.sv

// ==== src/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            den,
    input  wire  [3:0]                     dwen,
    input  wire  [31:0]                    daddr,
    input  wire  [31:0]                    wdata,
    input  wire                            uncached,
    output logic                           data_ok,
    output logic [31:0]                    rdata,
    output logic                           busy,
    output logic                           rd_req,
    output logic [31:0]                    rd_addr,
    output logic                           rd_uncached,
    input  wire                            rd_ack,
    input  wire                            rvalid,
    input  wire  [31:0]                    rdata_bus,
    input  wire                            rlast,
    input  wire  [dcache_pkg::LINE_W-1:0]  line,
    output logic                           ram_we,
    output logic                           ram_sel_refill,
    output logic [dcache_pkg::LINE_W-1:0]  ram_wd,
    output logic                           refill_clear,
    input  wire  [dcache_pkg::LINE_WORDS-1:0][31:0] refill_line,
    output logic                           wb_start,
    output logic                           uw_start,
    input  wire                            wb_idle,
    input  wire                            uw_done
);

    import dcache_pkg::*;

    logic [2:0]                  state, state_nxt;
    logic [LINES-1:0]            valid, dirty;
    dcache_addr_u                req, line_addr;
    logic [LINE_WORDS-1:0][31:0] stored_words, hit_words;
    logic [31:0]                 mask;
    logic                        hit, is_store;

    assign req          = daddr;
    assign is_store     = |dwen;
    assign stored_words = line[LINE_W-1:TAG_W];
    assign hit          = valid[req.f.index] && (line[TAG_W-1:0] == req.f.tag);
    assign mask         = {{8{dwen[3]}}, {8{dwen[2]}}, {8{dwen[1]}}, {8{dwen[0]}}};

    always_comb begin
        line_addr            = req; // Burst starts at word 0
        line_addr.f.offset   = '0;
        line_addr.f.byte_sel = '0;
    end

    always_comb begin
        hit_words = stored_words;
        hit_words[req.f.offset] = (stored_words[req.f.offset] & ~mask) | (wdata & mask);
    end

    assign ram_wd = ram_sel_refill ? {refill_line, req.f.tag} : {hit_words, req.f.tag};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (state == CS_REFILL) begin
            valid[req.f.index] <= 1'b1;
            dirty[req.f.index] <= is_store;
        end else if (ram_we) begin
            dirty[req.f.index] <= 1'b1; // Write hit
        end
    end

    always_comb begin
        state_nxt      = state;
        data_ok        = 1'b0;
        rdata          = 32'd0;
        busy           = 1'b1;
        rd_req         = 1'b0;
        rd_addr        = 32'd0;
        rd_uncached    = 1'b0;
        ram_we         = 1'b0;
        ram_sel_refill = 1'b0;
        refill_clear   = 1'b0;
        wb_start       = 1'b0;
        uw_start       = 1'b0;
        case (state)
            CS_IDLE: begin
                busy = 1'b0;
                if (den && uncached && is_store) begin
                    busy      = 1'b1;
                    uw_start  = 1'b1;
                    state_nxt = CS_UW_WAIT;
                end else if (den && uncached) begin
                    busy        = 1'b1;
                    rd_req      = 1'b1;
                    rd_addr     = req.flat;
                    rd_uncached = 1'b1;
                    state_nxt   = rd_ack ? CS_UR_RETURN : CS_UR_SHAKE;
                end else if (den && hit) begin
                    data_ok = 1'b1;
                    rdata   = stored_words[req.f.offset];
                    ram_we  = is_store;
                end else if (den) begin
                    busy         = 1'b1;
                    rd_req       = 1'b1;
                    rd_addr      = line_addr.flat;
                    refill_clear = 1'b1;
                    wb_start     = valid[req.f.index] && dirty[req.f.index];
                    state_nxt    = rd_ack ? CS_CR_WAIT : CS_CR_SHAKE;
                end
            end
            CS_UR_SHAKE: begin
                rd_req      = 1'b1;
                rd_addr     = req.flat;
                rd_uncached = 1'b1;
                if (rd_ack) state_nxt = CS_UR_RETURN;
            end
            CS_UR_RETURN: begin
                if (rvalid && rlast) begin
                    data_ok   = 1'b1;
                    rdata     = rdata_bus;
                    state_nxt = CS_IDLE;
                end
            end
            CS_UW_WAIT: begin
                if (uw_done) begin
                    data_ok   = 1'b1;
                    state_nxt = CS_IDLE;
                end
            end
            CS_CR_SHAKE: begin
                rd_req  = 1'b1;
                rd_addr = line_addr.flat;
                if (rd_ack) state_nxt = CS_CR_WAIT;
            end
            CS_CR_WAIT: begin
                if (rvalid && rlast) begin
                    state_nxt = wb_idle ? CS_REFILL : CS_WB_WAIT;
                end
            end
            CS_WB_WAIT: begin
                if (wb_idle) state_nxt = CS_REFILL; // Victim fully written out
            end
            CS_REFILL: begin
                ram_we         = 1'b1;
                ram_sel_refill = 1'b1;
                data_ok        = 1'b1;
                rdata          = refill_line[req.f.offset];
                state_nxt      = CS_IDLE;
            end
            default: state_nxt = CS_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/dcache_line_ram.sv ====
`default_nettype none

module dcache_line_ram (
    input  wire                           clk,
    input  wire  [dcache_pkg::INDEX_W-1:0] ra,
    input  wire  [dcache_pkg::INDEX_W-1:0] wa,
    input  wire  [dcache_pkg::LINE_W-1:0]  wd,
    input  wire                           we,
    output logic [dcache_pkg::LINE_W-1:0]  rd
);

    import dcache_pkg::*;

    // Each entry is {word15 .. word0, tag}
    logic [LINE_W-1:0] mem [LINES];

    assign rd = mem[ra]; // Async read port

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

endmodule

`default_nettype wire

// ==== src/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // Cache geometry
    localparam int TAG_W      = 19;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_LSB  = OFFSET_W + 2;
    localparam int LINES      = 128;
    localparam int LINE_WORDS = 16;
    localparam int LINE_W     = TAG_W + LINE_WORDS * 32; // Tag in the low bits

    // Controller states
    localparam logic [2:0] CS_IDLE      = 3'd0;
    localparam logic [2:0] CS_UR_SHAKE  = 3'd1;
    localparam logic [2:0] CS_UR_RETURN = 3'd2;
    localparam logic [2:0] CS_UW_WAIT   = 3'd3;
    localparam logic [2:0] CS_CR_SHAKE  = 3'd4;
    localparam logic [2:0] CS_CR_WAIT   = 3'd5;
    localparam logic [2:0] CS_WB_WAIT   = 3'd6;
    localparam logic [2:0] CS_REFILL    = 3'd7;

    // Write channel states
    localparam logic [2:0] WS_IDLE      = 3'd0;
    localparam logic [2:0] WS_UW_SHAKE  = 3'd1;
    localparam logic [2:0] WS_UW_WRITE  = 3'd2;
    localparam logic [2:0] WS_UW_RESULT = 3'd3;
    localparam logic [2:0] WS_WB_SHAKE  = 3'd4;
    localparam logic [2:0] WS_WB_WRITE  = 3'd5;
    localparam logic [2:0] WS_WB_RESULT = 3'd6;

    typedef union packed {
        logic [31:0] flat;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
            logic [1:0]          byte_sel;
        } f;
    } dcache_addr_u;

endpackage

`default_nettype wire

// ==== src/dcache_refill_buffer.sv ====
`default_nettype none

module dcache_refill_buffer (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             clear,
    input  wire                             rvalid,
    input  wire  [31:0]                     rdata,
    input  wire                             merge_en,
    input  wire  [dcache_pkg::OFFSET_W-1:0] merge_offset,
    input  wire  [3:0]                      merge_strb,
    input  wire  [31:0]                     merge_data,
    output logic [dcache_pkg::LINE_WORDS-1:0][31:0] line_words
);

    import dcache_pkg::*;

    logic [LINE_WORDS-1:0][31:0] words;
    logic [OFFSET_W-1:0]         beat;
    logic [31:0]                 mask;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            beat <= '0;
        end else if (rvalid) begin
            beat <= beat + 1'b1; // Wraps after the last beat
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid) begin
            words[beat] <= rdata;
        end
    end

    assign mask = {{8{merge_strb[3]}}, {8{merge_strb[2]}},
                   {8{merge_strb[1]}}, {8{merge_strb[0]}}};

    // Store miss: overlay the enabled bytes
    always_comb begin
        line_words = words;
        if (merge_en) begin
            line_words[merge_offset] = (words[merge_offset] & ~mask) | (merge_data & mask);
        end
    end

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  wire         clk,
    input  wire         rst,
    input  wire         den,
    input  wire  [3:0]  dwen,
    input  wire  [31:0] daddr,
    input  wire  [31:0] wdata,
    input  wire         uncached,
    output logic        data_ok,
    output logic [31:0] rdata,
    output logic        busy,
    output logic        rd_req,
    output logic [31:0] rd_addr,
    output logic        rd_uncached,
    input  wire         rd_ack,
    input  wire         rvalid,
    input  wire  [31:0] rdata_bus,
    input  wire         rlast,
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output logic        wr_uncached,
    output logic        wvalid,
    output logic [31:0] wdata_out,
    output logic [3:0]  wstrb,
    output logic        wlast,
    input  wire         wr_ack,
    input  wire         wready,
    input  wire         bvalid
);

    import dcache_pkg::*;

    logic [LINE_W-1:0]           ram_rd, ram_wd;
    logic [LINE_WORDS-1:0][31:0] refill_line;
    logic                        ram_we, ram_sel_refill, refill_clear;
    logic                        wb_start, uw_start, wb_idle, uw_done;

    dcache_ctrl u_ctrl (
        .clk, .rst, .den, .dwen, .daddr, .wdata, .uncached,
        .data_ok, .rdata, .busy,
        .rd_req, .rd_addr, .rd_uncached, .rd_ack, .rvalid, .rdata_bus, .rlast,
        .line           (ram_rd),
        .ram_we,
        .ram_sel_refill,
        .ram_wd,
        .refill_clear,
        .refill_line,
        .wb_start, .uw_start, .wb_idle, .uw_done
    );

    dcache_line_ram u_line_ram (
        .clk,
        .ra (daddr[INDEX_LSB +: INDEX_W]),
        .wa (daddr[INDEX_LSB +: INDEX_W]),
        .wd (ram_wd),
        .we (ram_we),
        .rd (ram_rd)
    );

    // Merge only applies in the refill cycle
    dcache_refill_buffer u_refill_buffer (
        .clk, .rst,
        .clear        (refill_clear),
        .rvalid,
        .rdata        (rdata_bus),
        .merge_en     (ram_sel_refill),
        .merge_offset (daddr[2 +: OFFSET_W]),
        .merge_strb   (dwen),
        .merge_data   (wdata),
        .line_words   (refill_line)
    );

    dcache_write_channel u_write_channel (
        .clk, .rst, .uw_start, .wb_start,
        .addr   (daddr),
        .wb_tag (ram_rd[TAG_W-1:0]),
        .dwen, .wdata,
        .line   (ram_rd),
        .wr_req, .wr_addr, .wr_uncached, .wvalid, .wdata_out, .wstrb, .wlast,
        .wr_ack, .wready, .bvalid, .wb_idle, .uw_done
    );

endmodule

`default_nettype wire

// ==== src/dcache_write_channel.sv ====
`default_nettype none

module dcache_write_channel (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            uw_start,
    input  wire                            wb_start,
    input  wire  [31:0]                    addr,
    input  wire  [dcache_pkg::TAG_W-1:0]   wb_tag,
    input  wire  [3:0]                     dwen,
    input  wire  [31:0]                    wdata,
    input  wire  [dcache_pkg::LINE_W-1:0]  line,
    output logic                           wr_req,
    output logic [31:0]                    wr_addr,
    output logic                           wr_uncached,
    output logic                           wvalid,
    output logic [31:0]                    wdata_out,
    output logic [3:0]                     wstrb,
    output logic                           wlast,
    input  wire                            wr_ack,
    input  wire                            wready,
    input  wire                            bvalid,
    output logic                           wb_idle,
    output logic                           uw_done
);

    import dcache_pkg::*;

    logic [2:0]                  state, state_nxt;
    logic [OFFSET_W-1:0]         beat;
    logic [LINE_WORDS-1:0][31:0] line_words;
    dcache_addr_u                req_addr, wb_addr;

    assign req_addr   = addr;
    assign line_words = line[LINE_W-1:TAG_W];
    assign wb_idle    = state == WS_IDLE;

    // Victim line address from the stored tag
    always_comb begin
        wb_addr            = req_addr;
        wb_addr.f.tag      = wb_tag;
        wb_addr.f.offset   = '0;
        wb_addr.f.byte_sel = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || wb_start) begin
            beat <= '0;
        end else if (state == WS_WB_WRITE && wready) begin
            beat <= beat + 1'b1;
        end
    end

    always_comb begin
        state_nxt   = state;
        wr_req      = 1'b0;
        wr_addr     = 32'd0;
        wr_uncached = 1'b0;
        wvalid      = 1'b0;
        wdata_out   = 32'd0;
        wstrb       = 4'd0;
        wlast       = 1'b0;
        uw_done     = 1'b0;
        case (state)
            WS_IDLE: begin
                if (wb_start) begin
                    state_nxt = WS_WB_SHAKE;
                end else if (uw_start) begin
                    state_nxt = WS_UW_SHAKE;
                end
            end
            WS_UW_SHAKE: begin
                wr_req      = 1'b1;
                wr_addr     = req_addr.flat;
                wr_uncached = 1'b1;
                if (wr_ack) state_nxt = WS_UW_WRITE;
            end
            WS_UW_WRITE: begin // Single beat with core strobes
                wvalid    = 1'b1;
                wdata_out = wdata;
                wstrb     = dwen;
                wlast     = 1'b1;
                if (wready) state_nxt = WS_UW_RESULT;
            end
            WS_UW_RESULT: begin
                if (bvalid) begin
                    uw_done   = 1'b1;
                    state_nxt = WS_IDLE;
                end
            end
            WS_WB_SHAKE: begin
                wr_req  = 1'b1;
                wr_addr = wb_addr.flat;
                if (wr_ack) state_nxt = WS_WB_WRITE;
            end
            WS_WB_WRITE: begin
                wvalid    = 1'b1;
                wdata_out = line_words[beat];
                wstrb     = 4'hf;
                wlast     = beat == OFFSET_W'(LINE_WORDS - 1);
                if (wready && wlast) state_nxt = WS_WB_RESULT;
            end
            WS_WB_RESULT: begin
                if (bvalid) state_nxt = WS_IDLE;
            end
            default: state_nxt = WS_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`default_nettype none

module mem_model #(
    parameter logic [31:0] SEED   = 32'h1,
    parameter int          MEM_AW = 14
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         rd_req,
    input  wire  [31:0] rd_addr,
    input  wire         rd_uncached,
    output logic        rd_ack,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic        rlast,
    input  wire         wr_req,
    input  wire  [31:0] wr_addr,
    input  wire         wvalid,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    input  wire         wlast,
    output logic        wr_ack,
    output logic        wready,
    output logic        bvalid
);

    localparam int MEM_WORDS = 1 << MEM_AW;

    logic [31:0]       words [MEM_WORDS];
    logic [31:0]       rd_rng, wr_rng;
    logic [MEM_AW-1:0] r_word, w_word;
    logic [4:0]        r_left;
    logic [1:0]        r_wait, w_wait;
    logic              rd_busy, w_busy, b_pend;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Preset contents, a different word at every address
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            words[i] = 32'(i) * 32'h9e37_79b1 + 32'h0f1e_2d3c;
        end
    end

    // Read channel
    always @(posedge clk) begin
        if (rst) begin
            rd_ack  <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= 32'd0;
            rlast   <= 1'b0;
            rd_busy <= 1'b0;
            r_wait  <= 2'd0;
            rd_rng  <= SEED;
        end else begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            rd_rng <= xorshift32(rd_rng);
            if (rd_ack) begin // Request taken at this edge
                rd_ack  <= 1'b0;
                rd_busy <= 1'b1;
                r_word  <= rd_addr[MEM_AW+1:2];
                r_left  <= rd_uncached ? 5'd1 : 5'd16;
                r_wait  <= rd_rng[1:0];
            end else if (rd_busy) begin
                if (r_wait != 2'd0) begin
                    r_wait <= r_wait - 2'd1;
                end else begin
                    rvalid <= 1'b1;
                    rdata  <= words[r_word];
                    rlast  <= r_left == 5'd1;
                    r_word <= r_word + MEM_AW'(1);
                    r_left <= r_left - 5'd1;
                    r_wait <= rd_rng[1:0];
                    if (r_left == 5'd1) rd_busy <= 1'b0;
                end
            end else if (rd_req) begin
                if (r_wait != 2'd0) r_wait <= r_wait - 2'd1;
                else rd_ack <= 1'b1;
            end else begin
                r_wait <= rd_rng[1:0];
            end
        end
    end

    // Write channel
    always @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            w_busy <= 1'b0;
            b_pend <= 1'b0;
            w_wait <= 2'd0;
            wr_rng <= SEED ^ 32'h6d2b_79f5;
        end else begin
            wr_rng <= xorshift32(wr_rng);
            if (wr_ack) begin
                wr_ack <= 1'b0;
                w_busy <= 1'b1;
                w_word <= wr_addr[MEM_AW+1:2];
                w_wait <= wr_rng[1:0];
            end else if (w_busy) begin
                if (wready) begin // Beat taken at this edge
                    wready <= 1'b0;
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            words[w_word][8*b +: 8] <= wdata[8*b +: 8];
                        end
                    end
                    w_word <= w_word + MEM_AW'(1);
                    w_wait <= wr_rng[1:0];
                    if (wlast) begin
                        w_busy <= 1'b0;
                        b_pend <= 1'b1;
                    end
                end else if (wvalid) begin
                    if (w_wait != 2'd0) w_wait <= w_wait - 2'd1;
                    else wready <= 1'b1;
                end
            end else if (b_pend) begin
                if (bvalid) begin
                    bvalid <= 1'b0;
                    b_pend <= 1'b0;
                    w_wait <= wr_rng[1:0];
                end else if (w_wait != 2'd0) begin
                    w_wait <= w_wait - 2'd1;
                end else begin
                    bvalid <= 1'b1;
                end
            end else if (wr_req) begin
                if (w_wait != 2'd0) w_wait <= w_wait - 2'd1;
                else wr_ack <= 1'b1;
            end else begin
                w_wait <= wr_rng[1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_dcache.sv ====
`default_nettype none

module tb_dcache;

    localparam logic [31:0] SEED = 32'hc2b491db;
    localparam int MEM_AW     = 14;
    localparam int MEM_WORDS  = 1 << MEM_AW;
    localparam int LINES      = 128;
    localparam int LINE_WORDS = 16;
    localparam int TEST_ACCESSES       = 60;
    localparam int WORST_ACCESS_CYCLES = 80; // Two overlapped bursts with gaps of up to 3
    localparam int TIMEOUT_CYCLES      = 10 * TEST_ACCESSES * WORST_ACCESS_CYCLES;

    localparam logic [31:0] ADDR_A = 32'h0000_1040; // Tag 0, index 0x41
    localparam logic [31:0] ADDR_B = 32'h0000_3040; // Tag 1, same index
    localparam logic [31:0] ADDR_C = 32'h0000_5048; // Tag 2, same index, word 2
    localparam logic [31:0] ADDR_D = 32'h0000_3080; // Index 0x42

    logic        clk = 1'b0;
    logic        rst;
    logic        den, uncached;
    logic [3:0]  dwen;
    logic [31:0] daddr, wdata;
    wire         data_ok, busy;
    wire  [31:0] rdata;
    wire         rd_req, rd_uncached, rd_ack, rvalid, rlast;
    wire  [31:0] rd_addr, rdata_bus;
    wire         wr_req, wr_uncached, wvalid, wlast, wr_ack, wready, bvalid;
    wire  [31:0] wr_addr, wdata_out;
    wire  [3:0]  wstrb;

    // Reference memory and a shadow of the cache lines
    logic [31:0] ref_mem  [MEM_WORDS];
    logic        rc_valid [LINES];
    logic        rc_dirty [LINES];
    logic [18:0] rc_tag   [LINES];
    logic [31:0] rc_data  [LINES * LINE_WORDS];

    logic [31:0] rnd;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int test_err_start = 0;
    int cycle_count = 0;

    dcache_top DUT (
        .clk, .rst, .den, .dwen, .daddr, .wdata, .uncached,
        .data_ok, .rdata, .busy,
        .rd_req, .rd_addr, .rd_uncached, .rd_ack, .rvalid, .rdata_bus, .rlast,
        .wr_req, .wr_addr, .wr_uncached, .wvalid, .wdata_out, .wstrb, .wlast,
        .wr_ack, .wready, .bvalid
    );

    mem_model #(.SEED(SEED), .MEM_AW(MEM_AW)) mem_i (
        .clk, .rst, .rd_req, .rd_addr, .rd_uncached, .rd_ack, .rvalid,
        .rdata (rdata_bus),
        .rlast, .wr_req, .wr_addr, .wvalid,
        .wdata (wdata_out),
        .wstrb, .wlast, .wr_ack, .wready, .bvalid
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no data_ok from the DUT within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // Uncached writes are flagged, write-back bursts are not
    always @(posedge clk) begin
        if (!rst && wr_req && wr_ack) begin
            check("wr_uncached", 32'(wr_uncached), 32'(uncached));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] m;
        m = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) m[8*b +: 8] = new_w[8*b +: 8];
        end
        return m;
    endfunction

    function automatic int line_base(input logic [18:0] tag, input logic [6:0] idx);
        logic [31:0] a;
        a = {tag, idx, 6'd0};
        return int'(a[MEM_AW+1:2]);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %08h expected %08h at cycle %0d", name, got, exp, cycle_count);
        end
    endtask

    // Expected outcome of one access
    // Dirty data reaches memory only on eviction
    task automatic model_access(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] data, input logic unc,
                                output logic hit, output logic [31:0] exp);
        logic [18:0] tag;
        logic [6:0]  idx;
        int          w, slot, base;
        tag  = addr[31:13];
        idx  = addr[12:6];
        w    = int'(addr[MEM_AW+1:2]);
        slot = int'(idx) * LINE_WORDS + int'(addr[5:2]);
        hit  = 1'b0;
        if (unc) begin
            exp        = ref_mem[w];
            ref_mem[w] = merge_bytes(ref_mem[w], data, be);
        end else begin
            hit = rc_valid[idx] && rc_tag[idx] == tag;
            if (!hit) begin
                if (rc_valid[idx] && rc_dirty[idx]) begin
                    base = line_base(rc_tag[idx], idx);
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        ref_mem[base + i] = rc_data[int'(idx) * LINE_WORDS + i];
                    end
                end
                base = line_base(tag, idx);
                for (int i = 0; i < LINE_WORDS; i++) begin
                    rc_data[int'(idx) * LINE_WORDS + i] = ref_mem[base + i];
                end
                rc_valid[idx] = 1'b1;
                rc_tag[idx]   = tag;
                rc_dirty[idx] = 1'b0;
            end
            exp = rc_data[slot];
            if (be != 4'd0) begin
                rc_data[slot] = merge_bytes(rc_data[slot], data, be);
                rc_dirty[idx] = 1'b1;
            end
        end
    endtask

    task automatic access(input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] data, input logic unc);
        logic        exp_hit;
        logic [31:0] exp;
        int          waited;
        model_access(addr, be, data, unc, exp_hit, exp);
        @(negedge clk);
        den      = 1'b1;
        dwen     = be;
        daddr    = addr;
        wdata    = data;
        uncached = unc;
        #1;
        check("busy", 32'(busy), exp_hit ? 32'd0 : 32'd1);
        waited = 0;
        while (!data_ok) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (exp_hit) check("hit_latency", 32'(waited), 32'd0); // Same cycle as den
        if (be == 4'd0) check("rdata", rdata, exp);
        @(negedge clk);
        den = 1'b0;
    endtask

    task automatic check_mem(input logic [31:0] addr, input int n);
        int w;
        w = int'(addr[MEM_AW+1:2]);
        for (int i = 0; i < n; i++) begin
            check($sformatf("mem[%04h]", w + i), mem_i.words[w + i], ref_mem[w + i]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_err_start);
        test_err_start = errors;
    endtask

    task automatic test_miss_then_hit();
        access(ADDR_A, 4'd0, 32'd0, 1'b0);
        access(ADDR_A, 4'd0, 32'd0, 1'b0);
        access(ADDR_A + 32'd60, 4'd0, 32'd0, 1'b0); // Last word of the line
        end_test("read_miss_then_hit");
    endtask

    task automatic test_write_hit();
        access(ADDR_A + 32'd4, 4'b0110, 32'hdead_beef, 1'b0);
        access(ADDR_A + 32'd4, 4'd0, 32'd0, 1'b0);
        check_mem(ADDR_A, LINE_WORDS); // Still the old words
        end_test("write_hit_partial");
    endtask

    task automatic test_dirty_eviction();
        access(ADDR_B, 4'd0, 32'd0, 1'b0);
        check_mem(ADDR_A, LINE_WORDS);
        access(ADDR_B + 32'd12, 4'd0, 32'd0, 1'b0);
        end_test("dirty_eviction");
    endtask

    task automatic test_store_miss();
        access(ADDR_C, 4'b1001, 32'ha5c3_3c5a, 1'b0);
        access(ADDR_C, 4'd0, 32'd0, 1'b0);
        access(ADDR_A, 4'd0, 32'd0, 1'b0); // Evicts the stored line
        check_mem(ADDR_C & ~32'h3f, LINE_WORDS);
        end_test("store_miss");
    endtask

    task automatic test_uncached();
        access(ADDR_D, 4'd0, 32'd0, 1'b0);
        access(ADDR_D, 4'b0011, 32'h1234_5678, 1'b1);
        check_mem(ADDR_D, 1);
        access(ADDR_D, 4'd0, 32'd0, 1'b0); // Cached copy keeps the old word
        access(ADDR_D, 4'd0, 32'd0, 1'b1);
        access(ADDR_D + 32'd4, 4'b1100, 32'h9abc_def0, 1'b1);
        access(ADDR_D + 32'd4, 4'd0, 32'd0, 1'b1);
        check_mem(ADDR_D, 2);
        end_test("uncached");
    endtask

    task automatic test_random_mix();
        logic [31:0] addr, data;
        logic [6:0]  idx;
        logic [3:0]  be;
        logic        unc;
        for (int n = 0; n < 40; n++) begin
            rnd = xorshift32(rnd);
            case (rnd[1:0])
                2'd0: idx = 7'h41;
                2'd1: idx = 7'h42;
                default: idx = 7'h05;
            endcase
            addr = {17'd0, rnd[3:2], idx, rnd[7:4], 2'b00}; // Tags 0 to 3
            unc  = rnd[10:8] == 3'd0;
            be   = rnd[11] ? rnd[15:12] : 4'd0;
            data = xorshift32(rnd ^ 32'h5bd1_e995);
            access(addr, be, data, unc);
        end
        check_mem(32'd0, MEM_WORDS);
        end_test("random_mix");
    endtask

    initial begin
        rst      = 1'b1;
        den      = 1'b0;
        dwen     = 4'd0;
        daddr    = 32'd0;
        wdata    = 32'd0;
        uncached = 1'b0;
        rnd      = SEED;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = mem_i.words[i];
        end
        for (int j = 0; j < LINES; j++) begin
            rc_valid[j] = 1'b0;
            rc_dirty[j] = 1'b0;
        end

        test_miss_then_hit();
        test_write_hit();
        test_dirty_eviction();
        test_store_miss();
        test_uncached();
        test_random_mix();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
